// File: hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  // Data and address width of the OBI data port
  localparam int LSU_DATA_W = 32;

  // One enable per byte lane
  localparam int LSU_BE_W = LSU_DATA_W / 8;

  // Byte offset inside a bus word
  localparam int LSU_OFFS_W = 2;

  ////////////////////////////////////////
  // Outstanding transactions
  ////////////////////////////////////////

  // Bus may hold at most this many granted accesses without a response
  localparam int LSU_DEPTH = 2;

  // Counter must reach LSU_DEPTH itself
  localparam int LSU_CNT_W = 2;

  ////////////////////////////////////////
  // Access size
  ////////////////////////////////////////

  // Encoding follows the funct3 size field of loads and stores
  typedef enum logic [1:0] {
    LSU_BYTE = 2'd0,
    LSU_HALF = 2'd1,
    LSU_WORD = 2'd2
  } lsu_size_e;

endpackage

`default_nettype wire

// File: hw/lsu_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lsu_xfer_if;
  import lsu_pkg::*;

  // EX address phase done, per-access control moves towards WB
  logic                  update;

  // Per-access control from the EX side
  lsu_size_e             size;
  logic                  sext;
  logic                  we;
  logic [LSU_OFFS_W-1:0] offset;
  // Current phase is the first half of a split access
  logic                  split_next;

  // Bus response, forwarded by the transaction control
  logic                  resp_valid;
  logic [LSU_DATA_W-1:0] resp_rdata;

  // Address and alignment logic in EX
  modport addr_side (input update, output size, sext, we, offset, split_next);

  // Handshake and counter logic
  modport ctrl_side (output update, resp_valid, resp_rdata, input split_next);

  // Read data path in WB
  modport wb_side (
    input update, size, sext, we, offset, split_next, resp_valid, resp_rdata
  );

endinterface

`default_nettype wire

// File: hw/lsu_addr_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_align (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            valid_0_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  operand_a_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  operand_b_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  wdata_i,
  input  logic                            we_i,
  input  lsu_pkg::lsu_size_e              size_i,
  input  logic                            sext_i,
  output logic [lsu_pkg::LSU_DATA_W-1:0]  addr_o,
  output logic [lsu_pkg::LSU_DATA_W-1:0]  wdata_o,
  output logic [lsu_pkg::LSU_BE_W-1:0]    be_o,
  output logic                            split_0_o,
  lsu_xfer_if.addr_side                   xfer
);
  import lsu_pkg::*;

  logic [LSU_DATA_W-1:0]   addr_sum;
  logic [LSU_OFFS_W-1:0]   offset;
  // Second address phase of a split access in progress
  logic                    split_q;
  logic                    needs_split;
  logic [2*LSU_DATA_W-1:0] wdata_dbl;
  logic [5:0]              rot_base;

  ////////////////////////////////////////
  // Address
  ////////////////////////////////////////

  assign addr_sum = operand_a_i + operand_b_i;
  assign offset   = addr_sum[LSU_OFFS_W-1:0];

  // Word crossing a word boundary, or halfword in the top byte
  assign needs_split = ((size_i == LSU_WORD) && (offset != '0)) ||
                       ((size_i == LSU_HALF) && (offset == 2'd3));

  // Only the first phase reports split
  assign split_0_o = valid_0_i && !split_q && needs_split;

  // Second phase goes to the following word
  assign addr_o = split_q ? ({addr_sum[LSU_DATA_W-1:2], 2'b00} + LSU_DATA_W'(4)) : addr_sum;

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  always_comb begin
    case (size_i)
      LSU_BYTE: begin
        be_o = 4'b0001 << offset;
      end
      LSU_HALF: begin
        // Only offset 3 reaches a second phase, with one byte left
        be_o = split_q ? 4'b0001 : (4'b0011 << offset);
      end
      default: begin
        // Lanes dropped in the first phase come back in the second
        be_o = split_q ? ~(4'b1111 << offset) : (4'b1111 << offset);
      end
    endcase
  end

  ////////////////////////////////////////
  // Store data
  ////////////////////////////////////////

  // Rotate left by the byte offset so byte 0 lands on its lane
  // Both phases use the same rotation
  assign wdata_dbl = {wdata_i, wdata_i};
  assign rot_base  = 6'd32 - {1'b0, offset, 3'b000};
  assign wdata_o   = wdata_dbl[rot_base +: LSU_DATA_W];

  ////////////////////////////////////////
  // Split tracking
  ////////////////////////////////////////

  // Killed access leaves no stale phase behind
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;
    end else if (xfer.update) begin
      split_q <= split_0_o;
    end
  end

  // Per-access control towards WB
  assign xfer.size       = size_i;
  assign xfer.sext       = sext_i;
  assign xfer.we         = we_i;
  assign xfer.offset     = offset;
  assign xfer.split_next = split_0_o;

  // Second phase only ever follows an access that needed it
  a_split_on_aligned_word: assert property (
    @(posedge clk) disable iff (!rst_n)
    (split_q && valid_0_i) |-> !((size_i == LSU_WORD) && (offset == '0))
  );

endmodule

`default_nettype wire

// File: hw/lsu_txn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_txn_ctrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            valid_0_i,
  input  logic                            ready_0_i,
  input  logic                            valid_1_i,
  input  logic                            ready_1_i,
  output logic                            ready_0_o,
  output logic                            valid_0_o,
  output logic                            ready_1_o,
  output logic                            valid_1_o,
  output logic                            busy_o,
  output logic                            data_req_o,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  data_rdata_i,
  lsu_xfer_if.ctrl_side                   xfer
);
  import lsu_pkg::*;

  // Outstanding transactions on the bus
  logic [LSU_CNT_W-1:0] cnt_q;
  logic [LSU_CNT_W-1:0] cnt_d;
  // EX access granted but EX not yet done
  logic                 granted_q;
  logic                 grant;
  logic                 ex_active;
  logic                 done_0;

  ////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////

  // No new request once LSU_DEPTH are outstanding
  assign data_req_o = valid_0_i && !granted_q && (cnt_q < LSU_CNT_W'(LSU_DEPTH));
  assign grant      = data_req_o && data_gnt_i;

  // Response goes straight on to the WB side
  assign xfer.resp_valid = data_rvalid_i;
  assign xfer.resp_rdata = data_rdata_i;

  ////////////////////////////////////////
  // EX stage
  ////////////////////////////////////////

  assign ex_active = valid_0_i || granted_q;

  // Idle EX is always done
  // Otherwise the address phase needs its grant and a free next stage
  assign done_0 = !ex_active || ((grant || granted_q) && ready_0_i);

  assign xfer.update = done_0 && ex_active;

  // Hold EX while the second phase of a split access is still to come
  assign ready_0_o = done_0 && !xfer.split_next;
  assign valid_0_o = valid_0_i && (grant || granted_q);

  // Grant seen while the pipeline stalls EX
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      granted_q <= 1'b0;
    end else if (xfer.update) begin
      granted_q <= 1'b0;
    end else if (grant) begin
      granted_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // WB stage
  ////////////////////////////////////////

  assign ready_1_o = ready_1_i && ((cnt_q == '0) || data_rvalid_i);
  // Pulses for each half of a split access
  assign valid_1_o = data_rvalid_i && valid_1_i;

  ////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////

  always_comb begin
    case ({grant, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign busy_o = data_req_o || (cnt_q != '0);

  // Bus keeps within the outstanding limit
  a_cnt_limit: assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= LSU_CNT_W'(LSU_DEPTH)
  );

  // Every response belongs to an earlier grant
  a_rvalid_owned: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0)
  );

  // OBI request stays up until granted
  a_req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> data_req_o
  );

endmodule

`default_nettype wire

// File: hw/lsu_rdata_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align (
  input  logic                            clk,
  input  logic                            rst_n,
  lsu_xfer_if.wb_side                     xfer,
  output logic [lsu_pkg::LSU_DATA_W-1:0]  rdata_1_o
);
  import lsu_pkg::*;

  // Control of each outstanding access, in bus order
  lsu_size_e             size_q [LSU_DEPTH];
  logic                  sext_q [LSU_DEPTH];
  logic                  we_q   [LSU_DEPTH];
  logic [LSU_OFFS_W-1:0] offs_q [LSU_DEPTH];
  // Low for the first half of a split access
  logic                  last_q [LSU_DEPTH];
  // One-bit pointers cover two entries
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;

  // Control of the access that responds next
  lsu_size_e             h_size;
  logic                  h_sext;
  logic                  h_we;
  logic [LSU_OFFS_W-1:0] h_offs;
  logic                  h_last;

  logic [LSU_DATA_W-1:0]   rdata_q;
  logic                    is_split;
  logic [2*LSU_DATA_W-1:0] rdata_full;
  logic [LSU_DATA_W-1:0]   rdata_al;
  logic [LSU_DATA_W-1:0]   rdata_ext;

  ////////////////////////////////////////
  // Control queue
  ////////////////////////////////////////

  // Written on update, read back on the matching response
  always_ff @(posedge clk) begin
    if (xfer.update) begin
      size_q[wr_ptr_q] <= xfer.size;
      sext_q[wr_ptr_q] <= xfer.sext;
      we_q[wr_ptr_q]   <= xfer.we;
      offs_q[wr_ptr_q] <= xfer.offset;
      last_q[wr_ptr_q] <= !xfer.split_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (xfer.update) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (xfer.resp_valid) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  assign h_size = size_q[rd_ptr_q];
  assign h_sext = sext_q[rd_ptr_q];
  assign h_we   = we_q[rd_ptr_q];
  assign h_offs = offs_q[rd_ptr_q];
  assign h_last = last_q[rd_ptr_q];

  ////////////////////////////////////////
  // Realignment and extension
  ////////////////////////////////////////

  assign is_split = ((h_size == LSU_WORD) && (h_offs != '0)) ||
                    ((h_size == LSU_HALF) && (h_offs == 2'd3));

  // Lower bytes of a split load come from the first response
  assign rdata_full = is_split ? {xfer.resp_rdata, rdata_q} :
                                 {xfer.resp_rdata, xfer.resp_rdata};

  // Drop offset bytes, max base 24 stays inside the 64-bit window
  assign rdata_al = rdata_full[{h_offs, 3'b000} +: LSU_DATA_W];

  always_comb begin
    case (h_size)
      LSU_BYTE: rdata_ext = {{24{h_sext && rdata_al[7]}}, rdata_al[7:0]};
      LSU_HALF: rdata_ext = {{16{h_sext && rdata_al[15]}}, rdata_al[15:0]};
      default:  rdata_ext = rdata_al;
    endcase
  end

  // Keep the raw first half for the merge
  always_ff @(posedge clk) begin
    if (xfer.resp_valid && !h_we) begin
      rdata_q <= h_last ? rdata_ext : xfer.resp_rdata;
    end
  end

  // Valid on the final response only
  assign rdata_1_o = rdata_ext;

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                            clk,
  input  logic                            rst_n,
  // EX stage access
  input  logic                            valid_0_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  operand_a_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  operand_b_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  wdata_i,
  input  logic                            we_i,
  input  lsu_pkg::lsu_size_e              size_i,
  input  logic                            sext_i,
  output logic                            split_0_o,
  // Pipeline handshakes
  output logic                            ready_0_o,
  output logic                            valid_0_o,
  input  logic                            ready_0_i,
  input  logic                            valid_1_i,
  output logic                            ready_1_o,
  output logic                            valid_1_o,
  input  logic                            ready_1_i,
  // OBI data bus
  output logic [lsu_pkg::LSU_DATA_W-1:0]  data_addr_o,
  output logic                            data_we_o,
  output logic [lsu_pkg::LSU_BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::LSU_DATA_W-1:0]  data_wdata_o,
  output logic                            data_req_o,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic [lsu_pkg::LSU_DATA_W-1:0]  data_rdata_i,
  // WB stage result
  output logic [lsu_pkg::LSU_DATA_W-1:0]  rdata_1_o,
  output logic                            busy_o
);

  lsu_xfer_if xfer ();

  ////////////////////////////////////////
  // EX side address and data
  ////////////////////////////////////////

  lsu_addr_align u_addr_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_0_i   (valid_0_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .wdata_i     (wdata_i),
    .we_i        (we_i),
    .size_i      (size_i),
    .sext_i      (sext_i),
    .addr_o      (data_addr_o),
    .wdata_o     (data_wdata_o),
    .be_o        (data_be_o),
    .split_0_o   (split_0_o),
    .xfer        (xfer.addr_side)
  );

  // Write strobe is the access direction itself
  assign data_we_o = xfer.we;

  // Handshakes and outstanding count
  lsu_txn_ctrl u_txn_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_0_i     (valid_0_i),
    .ready_0_i     (ready_0_i),
    .valid_1_i     (valid_1_i),
    .ready_1_i     (ready_1_i),
    .ready_0_o     (ready_0_o),
    .valid_0_o     (valid_0_o),
    .ready_1_o     (ready_1_o),
    .valid_1_o     (valid_1_o),
    .busy_o        (busy_o),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .xfer          (xfer.ctrl_side)
  );

  // WB side read data
  lsu_rdata_align u_rdata_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .xfer      (xfer.wb_side),
    .rdata_1_o (rdata_1_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  // Half of the 100 ns period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD;
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: tests/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  // Watchdog budget is the access count of all tests times a worst case per access
  localparam int N_ACCESS   = 50;
  localparam int ACC_CYCLES = 40;
  localparam int MEM_WORDS  = 256;
  localparam int N_B2B      = 16;

  logic        clk;
  logic        rst_n;
  logic        valid_0_i, we_i, sext_i, ready_0_i, valid_1_i, ready_1_i;
  logic [31:0] operand_a_i, operand_b_i, wdata_i;
  lsu_size_e   size_i;
  logic        split_0_o, ready_0_o, valid_0_o, ready_1_o, valid_1_o, busy_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i, rdata_1_o;
  logic [3:0]  data_be_o;
  logic        data_we_o, data_req_o, data_gnt_i, data_rvalid_i;

  // Bus side memory and the expected byte image
  logic [31:0] mem [MEM_WORDS];
  logic [7:0]  ref_bytes [4*MEM_WORDS];
  integer      seed = 65131;
  int          cyc, gnt_wait, last_due, widx, due;
  int          outstanding, max_outstanding;
  int          errors;
  logic        exp_ready_1;
  // Pending responses in bus order
  logic [31:0] rsp_data_q [$];
  int          rsp_due_q [$];
  // Granted requests and load results as seen by the tests
  logic [31:0] g_addr_q [$];
  logic        g_we_q [$];
  logic [3:0]  g_be_q [$];
  logic [31:0] g_wdata_q [$];
  logic [31:0] result_q [$];

  tb_clk_gen u_clk_gen (.clk_o(clk));

  lsu_top u_lsu_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_0_i     (valid_0_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .wdata_i       (wdata_i),
    .we_i          (we_i),
    .size_i        (size_i),
    .sext_i        (sext_i),
    .split_0_o     (split_0_o),
    .ready_0_o     (ready_0_o),
    .valid_0_o     (valid_0_o),
    .ready_0_i     (ready_0_i),
    .valid_1_i     (valid_1_i),
    .ready_1_o     (ready_1_o),
    .valid_1_o     (valid_1_o),
    .ready_1_i     (ready_1_i),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_1_o     (rdata_1_o),
    .busy_o        (busy_o)
  );

  ////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////

  // Sample the settled cycle, record grants and queue responses
  always @(negedge clk) begin
    // WB takes a result when nothing is outstanding or a response is present
    exp_ready_1 = ready_1_i && ((outstanding == 0) || data_rvalid_i);
    if (rst_n && ready_1_o !== exp_ready_1) begin
      report_mismatch("ready_1_o", 32'(exp_ready_1), 32'(ready_1_o));
    end
    if (data_req_o && data_gnt_i) begin
      g_addr_q.push_back(data_addr_o);
      g_we_q.push_back(data_we_o);
      g_be_q.push_back(data_be_o);
      g_wdata_q.push_back(data_wdata_o);
      widx = int'(data_addr_o[9:2]);
      if (data_we_o) begin
        for (int k = 0; k < 4; k++) begin
          if (data_be_o[k]) mem[widx][8*k +: 8] = data_wdata_o[8*k +: 8];
        end
      end
      // Due 1 to 3 cycles after the grant and never before the previous one
      due = cyc + 1 + int'($unsigned($random(seed)) % 3);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_data_q.push_back(data_we_o ? 32'h0 : mem[widx]);
      rsp_due_q.push_back(due);
      gnt_wait = int'($unsigned($random(seed)) % 4);
    end else if (data_req_o && gnt_wait > 0) begin
      gnt_wait = gnt_wait - 1;
    end
    outstanding = outstanding + ((data_req_o && data_gnt_i) ? 1 : 0) - (data_rvalid_i ? 1 : 0);
    if (outstanding > max_outstanding) max_outstanding = outstanding;
    if (valid_1_o) result_q.push_back(rdata_1_o);
  end

  // Bus inputs change a fixed delay after the rising edge
  always @(posedge clk) begin
    #10;
    cyc = cyc + 1;
    data_gnt_i = (gnt_wait == 0);
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = rsp_data_q.pop_front();
      rsp_due_q.delete(0);
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = 32'h0;
    end
  end

  ////////////////////////////////////////
  // Reference helpers
  ////////////////////////////////////////

  // Word index sets every byte, so each word differs
  function automatic logic [31:0] fill_word(input int idx);
    logic [7:0] w;
    w = idx[7:0];
    return {w ^ 8'hc3, w + 8'h61, ~w, w * 8'h1d};
  endfunction

  // Little endian bytes from the image, then extension
  function automatic logic [31:0] ref_load(input logic [31:0] addr, input lsu_size_e size,
                                           input logic sext);
    logic [31:0] val;
    int          n;
    n   = 1 << size;
    val = '0;
    for (int k = 0; k < n; k++) val[8*k +: 8] = ref_bytes[int'(addr[9:0]) + k];
    if (sext && n < 4 && val[8*n-1]) val = val | (32'hffff_ffff << (8*n));
    return val;
  endfunction

  function automatic void ref_store(input logic [31:0] addr, input lsu_size_e size,
                                    input logic [31:0] wd);
    for (int k = 0; k < (1 << size); k++) ref_bytes[int'(addr[9:0]) + k] = wd[8*k +: 8];
  endfunction

  // Byte 0 of the store moves to the lane of the offset
  function automatic logic [31:0] rotate_lanes(input logic [31:0] wd, input logic [1:0] off);
    int sh;
    sh = 8 * int'(off);
    return (wd << sh) | (wd >> (32 - sh));
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors = errors + 1;
    $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp_v, act_v);
  endtask

  task automatic report_failure(input string what);
    errors = errors + 1;
    $display("[ERROR] t=%0t %s", $time, what);
  endtask

  task automatic close_test(input string name, input int err0);
    $display("test %-14s done with %0d errors", name, errors - err0);
  endtask

  ////////////////////////////////////////
  // Access sequencing
  ////////////////////////////////////////

  // Drive one access and hold it until EX completes
  task automatic issue(input logic we, input lsu_size_e size, input logic sext,
                       input logic [31:0] addr, input logic [31:0] wd, output logic split_seen);
    int   n;
    logic accepted;
    @(posedge clk);
    #10;
    valid_0_i   = 1'b1;
    we_i        = we;
    size_i      = size;
    sext_i      = sext;
    // Carry through the adder
    operand_a_i = addr - 32'd7;
    operand_b_i = 32'd7;
    wdata_i     = wd;
    split_seen  = 1'b0;
    accepted    = 1'b0;
    n           = 0;
    while (!accepted && n < ACC_CYCLES) begin
      @(negedge clk);
      if (split_0_o) split_seen = 1'b1;
      accepted = valid_0_o && ready_0_o;
      n = n + 1;
    end
    if (!accepted) report_failure($sformatf("EX handshake never completed at 0x%08h", addr));
  endtask

  task automatic release_ex;
    @(posedge clk);
    #10;
    valid_0_i = 1'b0;
  endtask

  task automatic wait_results(input int n);
    int t;
    t = 0;
    while (result_q.size() < n && t < ACC_CYCLES) begin
      @(negedge clk);
      t = t + 1;
    end
    if (result_q.size() < n) begin
      report_failure($sformatf("only %0d of %0d WB results arrived", result_q.size(), n));
    end
  endtask

  task automatic wait_idle;
    int t;
    t = 0;
    @(negedge clk);
    while (busy_o && t < ACC_CYCLES) begin
      @(negedge clk);
      t = t + 1;
    end
    if (busy_o !== 1'b0) report_failure("busy_o stayed high after all responses");
  endtask

  // One access with bus, split and result checks
  task automatic run_access(input logic we, input lsu_size_e size, input logic sext,
                            input logic [31:0] addr, input logic [31:0] wd);
    logic        split_seen;
    logic        crosses;
    logic [31:0] exp_data;
    logic [31:0] exp_addr;
    logic [7:0]  lanes;
    int          nbytes;
    int          phases;
    nbytes   = 1 << size;
    // Lanes over this word and the next one
    lanes    = ((8'd1 << nbytes) - 8'd1) << addr[1:0];
    crosses  = (int'(addr[1:0]) + nbytes) > 4;
    phases   = crosses ? 2 : 1;
    exp_data = ref_load(addr, size, sext);
    result_q.delete();
    g_addr_q.delete();
    g_we_q.delete();
    g_be_q.delete();
    g_wdata_q.delete();
    issue(we, size, sext, addr, wd, split_seen);
    release_ex();
    wait_results(phases);
    wait_idle();
    if (split_seen !== crosses) report_mismatch("split_0_o", 32'(crosses), 32'(split_seen));
    if (g_addr_q.size() != phases) begin
      report_failure($sformatf("%0d bus requests at 0x%08h, expected %0d",
                               g_addr_q.size(), addr, phases));
    end else begin
      for (int p = 0; p < phases; p++) begin
        exp_addr = (p == 0) ? addr : ({addr[31:2], 2'b00} + 32'd4);
        if (g_addr_q[p] !== exp_addr) report_mismatch("data_addr_o", exp_addr, g_addr_q[p]);
        if (g_we_q[p] !== we) report_mismatch("data_we_o", 32'(we), 32'(g_we_q[p]));
        if (g_be_q[p] !== ((p == 0) ? lanes[3:0] : lanes[7:4])) begin
          report_mismatch("data_be_o", 32'((p == 0) ? lanes[3:0] : lanes[7:4]), 32'(g_be_q[p]));
        end
        if (we && g_wdata_q[p] !== rotate_lanes(wd, addr[1:0])) begin
          report_mismatch("data_wdata_o", rotate_lanes(wd, addr[1:0]), g_wdata_q[p]);
        end
      end
    end
    if (result_q.size() != phases) begin
      report_failure($sformatf("valid_1_o pulsed %0d times, expected %0d",
                               result_q.size(), phases));
    end else if (!we && result_q[phases-1] !== exp_data) begin
      report_mismatch("rdata_1_o", exp_data, result_q[phases-1]);
    end
    if (we) ref_store(addr, size, wd);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset;
    int err0;
    err0 = errors;
    if (busy_o !== 1'b0) report_mismatch("busy_o", 32'd0, 32'(busy_o));
    if (data_req_o !== 1'b0) report_mismatch("data_req_o", 32'd0, 32'(data_req_o));
    if (ready_0_o !== 1'b1) report_mismatch("ready_0_o", 32'd1, 32'(ready_0_o));
    if (valid_0_o !== 1'b0) report_mismatch("valid_0_o", 32'd0, 32'(valid_0_o));
    if (valid_1_o !== 1'b0) report_mismatch("valid_1_o", 32'd0, 32'(valid_1_o));
    close_test("reset_state", err0);
  endtask

  // Unused upper bytes must not reach memory
  task automatic test_aligned_stores;
    int err0;
    err0 = errors;
    run_access(1'b1, LSU_WORD, 1'b0, 32'h40, 32'h1122_3344);
    run_access(1'b1, LSU_HALF, 1'b0, 32'h44, 32'hdead_a5b6);
    run_access(1'b1, LSU_HALF, 1'b0, 32'h46, 32'h1234_c7d8);
    run_access(1'b1, LSU_BYTE, 1'b0, 32'h49, 32'hffff_ff9e);
    run_access(1'b1, LSU_BYTE, 1'b0, 32'h4a, 32'h0000_0071);
    for (int w = 0; w < 3; w++) run_access(1'b0, LSU_WORD, 1'b0, 32'h40 + 32'(4*w), 32'h0);
    close_test("aligned_stores", err0);
  endtask

  task automatic test_narrow_loads;
    int err0;
    err0 = errors;
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < 4; off++) run_access(1'b0, LSU_BYTE, s[0], 32'h80 + 32'(off), 0);
      for (int off = 0; off < 3; off++) run_access(1'b0, LSU_HALF, s[0], 32'h84 + 32'(off), 0);
    end
    close_test("narrow_loads", err0);
  endtask

  task automatic test_split_access;
    int err0;
    err0 = errors;
    run_access(1'b0, LSU_WORD, 1'b0, 32'hc1, 32'h0);
    run_access(1'b0, LSU_HALF, 1'b1, 32'hc7, 32'h0);
    run_access(1'b1, LSU_WORD, 1'b0, 32'hd1, 32'hcafe_f00d);
    run_access(1'b1, LSU_HALF, 1'b0, 32'hd7, 32'h0000_b00c);
    for (int w = 0; w < 3; w++) run_access(1'b0, LSU_WORD, 1'b0, 32'hd0 + 32'(4*w), 32'h0);
    close_test("split_access", err0);
  endtask

  // Loads issued without gaps
  // Results compared in order
  task automatic test_back_to_back;
    int          err0;
    logic        split_seen;
    logic [31:0] addr;
    lsu_size_e   size;
    logic [31:0] exp_q [$];
    err0 = errors;
    result_q.delete();
    max_outstanding = 0;
    for (int i = 0; i < N_B2B; i++) begin
      size = lsu_size_e'($unsigned($random(seed)) % 3);
      addr = 32'h100 + 32'(4 * ($unsigned($random(seed)) % 32));
      // Naturally aligned, so no split
      addr = addr + (32'($unsigned($random(seed)) % 4) & ~32'((1 << size) - 1));
      exp_q.push_back(ref_load(addr, size, 1'b1));
      issue(1'b0, size, 1'b1, addr, 32'h0, split_seen);
      if (split_seen !== 1'b0) report_mismatch("split_0_o", 32'd0, 32'(split_seen));
    end
    release_ex();
    wait_results(N_B2B);
    wait_idle();
    for (int i = 0; i < N_B2B && i < result_q.size(); i++) begin
      if (result_q[i] !== exp_q[i]) report_mismatch("rdata_1_o", exp_q[i], result_q[i]);
    end
    if (max_outstanding > LSU_DEPTH) begin
      report_failure($sformatf("%0d transactions outstanding on the bus", max_outstanding));
    end
    close_test("back_to_back", err0);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    valid_0_i     = 1'b0;
    operand_a_i   = '0;
    operand_b_i   = '0;
    wdata_i       = '0;
    we_i          = 1'b0;
    size_i        = LSU_BYTE;
    sext_i        = 1'b0;
    ready_0_i     = 1'b1;
    valid_1_i     = 1'b1;
    ready_1_i     = 1'b1;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    errors        = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
      for (int k = 0; k < 4; k++) ref_bytes[4*i+k] = mem[i][8*k +: 8];
    end
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;
    @(negedge clk);
    test_reset();
    test_aligned_stores();
    test_narrow_loads();
    test_split_access();
    test_back_to_back();
    $display("Summary: 5 tests, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (N_ACCESS * ACC_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles", N_ACCESS * ACC_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f tb.f -Mdir obj_dir
	./obj_dir/Vlsu_tb > sim.log 2>&1; st=$$?; cat sim.log; exit $$st
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tb.f
hw/lsu_pkg.sv
hw/lsu_xfer_if.sv
hw/lsu_addr_align.sv
hw/lsu_txn_ctrl.sv
hw/lsu_rdata_align.sv
hw/lsu_top.sv
tests/tb_clk_gen.sv
tests/lsu_tb.sv
